/* hdl/apb_pkg.sv */
package apb_pkg;

    // ########################################
    // bus field types.
    // ########################################

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [2:0]  prot_t;

    // decoded target of an access.
    typedef enum logic [1:0] {
        region_fast,
        region_slow,
        region_none
    } region_t;

    // ########################################
    // address map by the top nibble of paddr.
    // ########################################

    localparam logic [3:0] fast_nibble    = 4'h0;
    localparam logic [3:0] slow_nibble_lo = 4'ha;
    localparam logic [3:0] slow_nibble_hi = 4'hb;

    function automatic region_t region_of(input addr_t addr);
        logic [3:0] nibble;
        nibble = addr[31:28];
        if (nibble == fast_nibble) begin
            return region_fast;
        end
        if (nibble == slow_nibble_lo || nibble == slow_nibble_hi) begin
            return region_slow;
        end
        return region_none;
    endfunction

endpackage

/* hdl/apb_if.sv */
`timescale 1ns/100ps

interface apb_if
    import apb_pkg::*;
();

    addr_t paddr;
    logic  psel;
    logic  penable;
    prot_t pprot;
    logic  pwrite;
    data_t pwdata;
    strb_t pstrb;
    logic  pready;
    data_t prdata;
    logic  pslverr;

    // side that starts transfers.
    modport requester (
        output paddr, psel, penable, pprot, pwrite, pwdata, pstrb,
        input  pready, prdata, pslverr
    );

    modport completer (
        input  paddr, psel, penable, pprot, pwrite, pwdata, pstrb,
        output pready, prdata, pslverr
    );

endinterface

/* hdl/apb_arbiter.sv */
`timescale 1ns/100ps

module apb_arbiter
    import apb_pkg::*;
(
    input  logic   clock,
    input  logic   reset,

    input  addr_t  a_paddr,
    input  logic   a_psel,
    input  logic   a_penable,
    input  prot_t  a_pprot,
    input  logic   a_pwrite,
    input  data_t  a_pwdata,
    input  strb_t  a_pstrb,
    output logic   a_pready,
    output data_t  a_prdata,
    output logic   a_pslverr,

    input  addr_t  b_paddr,
    input  logic   b_psel,
    input  logic   b_penable,
    input  prot_t  b_pprot,
    input  logic   b_pwrite,
    input  data_t  b_pwdata,
    input  strb_t  b_pstrb,
    output logic   b_pready,
    output data_t  b_prdata,
    output logic   b_pslverr,

    apb_if.requester bus
);

    typedef enum logic [1:0] {
        idle,
        owner_a,
        owner_b
    } owner_t;

    owner_t owner;
    logic   last_b;   // b was served last.
    logic   pick_a;
    logic   pick_b;
    logic   sel_a;
    logic   sel_b;
    logic   bus_done;

    // ########################################
    // grant is decided while the bus is free.
    // ########################################

    always_comb begin
        pick_a = 1'b0;
        pick_b = 1'b0;
        if (owner == idle) begin
            if (a_psel && b_psel) begin
                pick_a = last_b;
                pick_b = !last_b;
            end else begin
                pick_a = a_psel;
                pick_b = b_psel;
            end
        end
    end

    assign sel_a    = (owner == owner_a) || pick_a;
    assign sel_b    = (owner == owner_b) || pick_b;
    assign bus_done = bus.psel && bus.penable && bus.pready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            owner  <= idle;
            last_b <= 1'b1;   // so a wins the first tie.
        end else begin
            case (owner)
                idle: begin
                    if (pick_a) owner <= owner_a;
                    else if (pick_b) owner <= owner_b;
                end
                owner_a, owner_b: begin
                    if (bus_done) begin
                        owner  <= idle;
                        last_b <= (owner == owner_b);
                    end
                end
                default: owner <= idle;
            endcase
        end
    end

    // the grant cycle is the internal setup phase, even for a held loser.
    assign bus.psel    = sel_a ? a_psel : (sel_b ? b_psel : 1'b0);
    assign bus.penable = (owner != idle) && bus.psel;
    assign bus.paddr   = sel_b ? b_paddr  : a_paddr;
    assign bus.pprot   = sel_b ? b_pprot  : a_pprot;
    assign bus.pwrite  = sel_b ? b_pwrite : a_pwrite;
    assign bus.pwdata  = sel_b ? b_pwdata : a_pwdata;
    assign bus.pstrb   = sel_b ? b_pstrb  : a_pstrb;

    assign a_pready  = (owner == owner_a) && bus.pready;
    assign a_prdata  = (owner == owner_a) ? bus.prdata : '0;
    assign a_pslverr = (owner == owner_a) && bus.pslverr;
    assign b_pready  = (owner == owner_b) && bus.pready;
    assign b_prdata  = (owner == owner_b) ? bus.prdata : '0;
    assign b_pslverr = (owner == owner_b) && bus.pslverr;

endmodule

/* hdl/apb_delayer.sv */
`timescale 1ns/100ps

module apb_delayer
    import apb_pkg::*;
#(
    parameter int ratio_num = 4,   // main clock vs slave clock.
    parameter int ratio_den = 8
) (
    input  logic clock,
    input  logic reset,
    apb_if.completer up,
    apb_if.requester down
);

    localparam int          shift = $clog2(ratio_den);
    localparam logic [15:0] step  = 16'(ratio_num);

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_wait
    } state_t;

    state_t      state;
    logic [15:0] count;
    logic [15:0] scaled;
    logic        slow_setup;
    logic        release_now;
    data_t       rdata_r;
    logic        pslverr_r;

    // request side goes straight through.
    assign down.paddr   = up.paddr;
    assign down.psel    = up.psel;
    assign down.penable = up.penable;
    assign down.pprot   = up.pprot;
    assign down.pwrite  = up.pwrite;
    assign down.pwdata  = up.pwdata;
    assign down.pstrb   = up.pstrb;

    assign slow_setup = up.psel && !up.penable && (region_of(up.paddr) == region_slow);
    assign scaled     = (count + step) >> shift;   // includes the answering cycle.

    // ########################################
    // count slave cycles and then count down.
    // ########################################

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            count <= '0;
        end else begin
            case (state)
                st_idle: begin
                    count <= '0;
                    if (slow_setup) state <= st_req;
                end
                st_req: begin
                    if (down.pready) begin
                        state <= st_wait;
                        count <= (scaled == '0) ? 16'd1 : scaled;
                    end else begin
                        count <= count + step;
                    end
                end
                st_wait: begin
                    count <= count - 16'd1;
                    if (count == 16'd1) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == st_req && down.pready) begin
            rdata_r   <= down.prdata;
            pslverr_r <= down.pslverr;
        end
    end

    assign release_now = (state == st_wait) && (count == 16'd1);

    assign up.pready  = release_now || ((state == st_idle) && down.pready);
    assign up.prdata  = release_now ? rdata_r :
                        (state == st_idle) ? down.prdata : '0;
    assign up.pslverr = release_now ? pslverr_r :
                        ((state == st_idle) && down.pslverr);

endmodule

/* hdl/apb_decoder.sv */
`timescale 1ns/100ps

module apb_decoder
    import apb_pkg::*;
(
    apb_if.completer bus,
    apb_if.requester fast,
    apb_if.requester slow
);

    region_t region;
    logic    access;

    assign region = region_of(bus.paddr);
    assign access = bus.psel && bus.penable;

    // both rams see the request, only one gets psel.
    assign fast.paddr   = bus.paddr;
    assign fast.penable = bus.penable;
    assign fast.pprot   = bus.pprot;
    assign fast.pwrite  = bus.pwrite;
    assign fast.pwdata  = bus.pwdata;
    assign fast.pstrb   = bus.pstrb;
    assign fast.psel    = bus.psel && (region == region_fast);

    assign slow.paddr   = bus.paddr;
    assign slow.penable = bus.penable;
    assign slow.pprot   = bus.pprot;
    assign slow.pwrite  = bus.pwrite;
    assign slow.pwdata  = bus.pwdata;
    assign slow.pstrb   = bus.pstrb;
    assign slow.psel    = bus.psel && (region == region_slow);

    always_comb begin
        case (region)
            region_fast: begin
                bus.pready  = fast.pready;
                bus.prdata  = fast.prdata;
                bus.pslverr = fast.pslverr;
            end
            region_slow: begin
                bus.pready  = slow.pready;
                bus.prdata  = slow.prdata;
                bus.pslverr = slow.pslverr;
            end
            default: begin
                bus.pready  = access;   // unmapped, error on first access cycle.
                bus.prdata  = '0;
                bus.pslverr = access;
            end
        endcase
    end

endmodule

/* hdl/apb_ram.sv */
`timescale 1ns/100ps

module apb_ram
    import apb_pkg::*;
#(
    parameter int ram_words   = 256,
    parameter int wait_states = 0
) (
    input  logic clock,
    input  logic reset,
    apb_if.completer bus
);

    localparam int idx_w = $clog2(ram_words);

    data_t            mem [ram_words];
    logic [idx_w-1:0] idx;
    logic [7:0]       wait_cnt;
    logic             access;
    logic             done;   // this transfer has already completed.

    assign access = bus.psel && bus.penable;
    assign idx    = idx_w'((bus.paddr >> 2) % ram_words);

    assign bus.pready  = access && (wait_cnt == 8'(wait_states));
    assign bus.prdata  = mem[idx];
    assign bus.pslverr = 1'b0;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wait_cnt <= '0;
            done     <= 1'b0;
        end else if (!access) begin
            wait_cnt <= '0;
            done     <= 1'b0;
        end else begin
            if (!bus.pready) wait_cnt <= wait_cnt + 8'd1;
            if (bus.pready) done <= 1'b1;
        end
    end

    // ########################################
    // strobed write happens once per transfer.
    // ########################################

    always_ff @(posedge clock) begin
        if (bus.pready && bus.pwrite && !done) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.pstrb[i]) mem[idx][8*i +: 8] <= bus.pwdata[8*i +: 8];
            end
        end
    end

endmodule

/* hdl/apb_subsystem.sv */
`timescale 1ns/100ps

module apb_subsystem
    import apb_pkg::*;
#(
    parameter int ratio_num  = 4,
    parameter int ratio_den  = 8,   // power of two.
    parameter int ram_words  = 256,
    parameter int fast_waits = 0,
    parameter int slow_waits = 2
) (
    input  logic   clock,
    input  logic   reset,

    input  addr_t  a_paddr,
    input  logic   a_psel,
    input  logic   a_penable,
    input  prot_t  a_pprot,
    input  logic   a_pwrite,
    input  data_t  a_pwdata,
    input  strb_t  a_pstrb,
    output logic   a_pready,
    output data_t  a_prdata,
    output logic   a_pslverr,

    input  addr_t  b_paddr,
    input  logic   b_psel,
    input  logic   b_penable,
    input  prot_t  b_pprot,
    input  logic   b_pwrite,
    input  data_t  b_pwdata,
    input  strb_t  b_pstrb,
    output logic   b_pready,
    output data_t  b_prdata,
    output logic   b_pslverr
);

    apb_if bus_arb ();
    apb_if bus_dly ();
    apb_if bus_fast ();
    apb_if bus_slow ();

    // ########################################
    // arbiter, delayer, decoder, rams.
    // ########################################

    apb_arbiter arbiter (
        .clock     (clock),
        .reset     (reset),
        .a_paddr   (a_paddr),
        .a_psel    (a_psel),
        .a_penable (a_penable),
        .a_pprot   (a_pprot),
        .a_pwrite  (a_pwrite),
        .a_pwdata  (a_pwdata),
        .a_pstrb   (a_pstrb),
        .a_pready  (a_pready),
        .a_prdata  (a_prdata),
        .a_pslverr (a_pslverr),
        .b_paddr   (b_paddr),
        .b_psel    (b_psel),
        .b_penable (b_penable),
        .b_pprot   (b_pprot),
        .b_pwrite  (b_pwrite),
        .b_pwdata  (b_pwdata),
        .b_pstrb   (b_pstrb),
        .b_pready  (b_pready),
        .b_prdata  (b_prdata),
        .b_pslverr (b_pslverr),
        .bus       (bus_arb)
    );

    apb_delayer #(
        .ratio_num (ratio_num),
        .ratio_den (ratio_den)
    ) delayer (
        .clock (clock),
        .reset (reset),
        .up    (bus_arb),
        .down  (bus_dly)
    );

    apb_decoder decoder (
        .bus  (bus_dly),
        .fast (bus_fast),
        .slow (bus_slow)
    );

    apb_ram #(
        .ram_words   (ram_words),
        .wait_states (fast_waits)
    ) fast_ram (
        .clock (clock),
        .reset (reset),
        .bus   (bus_fast)
    );

    // slow completer adds its own wait states on top of the delayer.
    apb_ram #(
        .ram_words   (ram_words),
        .wait_states (slow_waits)
    ) slow_ram (
        .clock (clock),
        .reset (reset),
        .bus   (bus_slow)
    );

endmodule

/* dv/tb_apb_subsystem.sv */
`timescale 1ns/100ps

module tb_apb_subsystem
    import apb_pkg::*;
();

    localparam int ram_words        = 256;
    localparam int strobe_writes    = 64;
    localparam int random_per_port  = 100;
    localparam int unmapped_checks  = 16;
    localparam int total_transfers  = 4 * ram_words + 2 * strobe_writes
                                    + 2 * random_per_port + 4 * unmapped_checks;
    localparam int timeout_cycles   = 200 * total_transfers;

    localparam int tgt_fast = 0;
    localparam int tgt_slow = 1;
    localparam int tgt_none = 2;

    typedef struct packed {
        addr_t addr;
        logic  is_read;
        data_t got_data;
        data_t exp_data;
        logic  got_err;
        logic  exp_err;
    } result_t;

    logic  clock;
    logic  reset;
    addr_t a_paddr;
    logic  a_psel;
    logic  a_penable;
    prot_t a_pprot;
    logic  a_pwrite;
    data_t a_pwdata;
    strb_t a_pstrb;
    logic  a_pready;
    data_t a_prdata;
    logic  a_pslverr;
    addr_t b_paddr;
    logic  b_psel;
    logic  b_penable;
    prot_t b_pprot;
    logic  b_pwrite;
    data_t b_pwdata;
    strb_t b_pstrb;
    logic  b_pready;
    data_t b_prdata;
    logic  b_pslverr;

    data_t       fast_model [ram_words];
    data_t       slow_model [ram_words];
    result_t     results [$];
    result_t     entry;
    logic [31:0] lfsr;
    int          cycle_count = 0;

    apb_subsystem uut (
        .clock     (clock),
        .reset     (reset),
        .a_paddr   (a_paddr),
        .a_psel    (a_psel),
        .a_penable (a_penable),
        .a_pprot   (a_pprot),
        .a_pwrite  (a_pwrite),
        .a_pwdata  (a_pwdata),
        .a_pstrb   (a_pstrb),
        .a_pready  (a_pready),
        .a_prdata  (a_prdata),
        .a_pslverr (a_pslverr),
        .b_paddr   (b_paddr),
        .b_psel    (b_psel),
        .b_penable (b_penable),
        .b_pprot   (b_pprot),
        .b_pwrite  (b_pwrite),
        .b_pwdata  (b_pwdata),
        .b_pstrb   (b_pstrb),
        .b_pready  (b_pready),
        .b_prdata  (b_prdata),
        .b_pslverr (b_pslverr)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // ########################################
    // random numbers and the memory model.
    // ########################################

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic        bit_out;
        value = '0;
        for (int i = 0; i < count; i++) begin
            bit_out = lfsr[0];
            lfsr    = (lfsr >> 1) ^ (bit_out ? 32'h80200003 : 32'h0);
            value   = {value[30:0], bit_out};
        end
        return value;
    endfunction

    function automatic int target_of(input addr_t addr);
        case (addr[31:28])
            4'h0:       return tgt_fast;
            4'ha, 4'hb: return tgt_slow;
            default:    return tgt_none;
        endcase
    endfunction

    function automatic logic [3:0] random_nibble(input int tgt);
        logic [3:0] nibble;
        if (tgt == tgt_fast) return 4'h0;
        if (tgt == tgt_slow) return {3'b101, 1'(random_bits(1))};
        nibble = 4'(random_bits(4));
        while (target_of({nibble, 28'h0}) != tgt_none) begin
            nibble = 4'(random_bits(4));
        end
        return nibble;
    endfunction

    // random bits between nibble and word index alias onto the same word.
    function automatic addr_t make_addr(input logic [3:0] nibble, input int word);
        logic [17:0] alias_bits;
        alias_bits = 18'(random_bits(18));
        return {nibble, alias_bits, word[7:0], 2'b00};
    endfunction

    function automatic data_t expected_response(input addr_t addr, input logic write,
                                                input data_t wdata, input strb_t strb,
                                                output logic err);
        int    word;
        int    tgt;
        data_t cur;
        word = int'(addr[31:2]) % ram_words;
        tgt  = target_of(addr);
        err  = (tgt == tgt_none);
        if (tgt == tgt_none) return '0;   // unmapped addresses store nothing.
        cur = (tgt == tgt_fast) ? fast_model[word] : slow_model[word];
        if (write) begin
            for (int i = 0; i < 4; i++) begin
                if (strb[i]) cur[8*i +: 8] = wdata[8*i +: 8];
            end
            if (tgt == tgt_fast) fast_model[word] = cur;
            else slow_model[word] = cur;
        end
        return cur;
    endfunction

    function automatic void record_completion(input addr_t addr, input logic write,
                                              input data_t wdata, input strb_t strb,
                                              input data_t got_data, input logic got_err);
        result_t r;
        logic    exp_err;
        r.addr     = addr;
        r.is_read  = !write;
        r.got_data = got_data;
        r.got_err  = got_err;
        r.exp_data = expected_response(addr, write, wdata, strb, exp_err);
        r.exp_err  = exp_err;
        results.push_back(r);
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAIL at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("** FAIL **");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // ########################################
    // one requester driver per port.
    // ########################################

    task automatic transfer_on_a(input addr_t addr, input logic write, input data_t wdata,
                                 input strb_t strb, output int cycles);
        @(posedge clock);
        a_paddr   <= addr;
        a_pwrite  <= write;
        a_pwdata  <= wdata;
        a_pstrb   <= strb;
        a_psel    <= 1'b1;
        a_penable <= 1'b0;
        @(posedge clock);
        a_penable <= 1'b1;
        cycles = 1;
        @(negedge clock);
        while (!a_pready) begin
            @(negedge clock);
            cycles++;
        end
        record_completion(addr, write, wdata, strb, a_prdata, a_pslverr);
        @(posedge clock);
        a_psel    <= 1'b0;
        a_penable <= 1'b0;
    endtask

    task automatic transfer_on_b(input addr_t addr, input logic write, input data_t wdata,
                                 input strb_t strb, output int cycles);
        @(posedge clock);
        b_paddr   <= addr;
        b_pwrite  <= write;
        b_pwdata  <= wdata;
        b_pstrb   <= strb;
        b_psel    <= 1'b1;
        b_penable <= 1'b0;
        @(posedge clock);
        b_penable <= 1'b1;
        cycles = 1;
        @(negedge clock);
        while (!b_pready) begin
            @(negedge clock);
            cycles++;
        end
        record_completion(addr, write, wdata, strb, b_prdata, b_pslverr);
        @(posedge clock);
        b_psel    <= 1'b0;
        b_penable <= 1'b0;
    endtask

    // few words so both ports hit the same locations.
    task automatic random_traffic(input int port, input int count);
        addr_t addr;
        logic  write;
        data_t wdata;
        strb_t strb;
        int    cycles;
        int    tgt;
        for (int i = 0; i < count; i++) begin
            tgt   = (random_bits(1) == 32'd1) ? tgt_slow : tgt_fast;
            addr  = make_addr(random_nibble(tgt), int'(random_bits(3)));
            write = 1'(random_bits(1));
            wdata = random_bits(32);
            strb  = 4'(random_bits(4));
            if (port == 0) transfer_on_a(addr, write, wdata, strb, cycles);
            else transfer_on_b(addr, write, wdata, strb, cycles);
        end
    endtask

    // compare every completed transfer against the model.
    always @(posedge clock) begin
        while (results.size() != 0) begin
            entry = results.pop_front();
            check_value(32'(entry.got_err), 32'(entry.exp_err),
                        $sformatf("pslverr at %h", entry.addr));
            if (entry.is_read) begin
                check_value(entry.got_data, entry.exp_data,
                            $sformatf("read data at %h", entry.addr));
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            $display("the run timed out after %0d cycles", cycle_count);
            $display("** FAIL **");
            $fatal(1, "timeout");
        end
    end

    // ########################################
    // test sequence.
    // ########################################

    initial begin
        addr_t addr;
        data_t wdata;
        strb_t strb;
        int    cycles;
        int    word;
        lfsr      = 32'd49;
        reset     = 1'b1;
        a_paddr   = '0;
        a_psel    = 1'b0;
        a_penable = 1'b0;
        a_pprot   = '0;
        a_pwrite  = 1'b0;
        a_pwdata  = '0;
        a_pstrb   = '0;
        b_paddr   = '0;
        b_psel    = 1'b0;
        b_penable = 1'b0;
        b_pprot   = '0;
        b_pwrite  = 1'b0;
        b_pwdata  = '0;
        b_pstrb   = '0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value(32'(a_pready), 32'd0, "a_pready after reset");
        check_value(32'(b_pready), 32'd0, "b_pready after reset");

        for (int w = 0; w < ram_words; w++) begin   // fast region through a.
            wdata = random_bits(32);
            transfer_on_a(make_addr(4'h0, w), 1'b1, wdata, 4'hf, cycles);
        end
        for (int w = 0; w < ram_words; w++) begin
            transfer_on_a(make_addr(4'h0, w), 1'b0, '0, '0, cycles);
        end

        for (int i = 0; i < strobe_writes; i++) begin
            addr  = make_addr(4'h0, int'(random_bits(8)));
            wdata = random_bits(32);
            strb  = 4'(random_bits(4));
            transfer_on_a(addr, 1'b1, wdata, strb, cycles);
            transfer_on_a(addr, 1'b0, '0, '0, cycles);
        end

        // slow region through b with each access held back by the delayer.
        for (int w = 0; w < ram_words; w++) begin
            addr  = make_addr(random_nibble(tgt_slow), w);
            wdata = random_bits(32);
            transfer_on_b(addr, 1'b1, wdata, 4'hf, cycles);
            check_value(32'(cycles >= 3), 32'd1, "slow write completion delay");
        end
        for (int w = 0; w < ram_words; w++) begin
            addr = make_addr(random_nibble(tgt_slow), w);
            transfer_on_b(addr, 1'b0, '0, '0, cycles);
            check_value(32'(cycles >= 3), 32'd1, "slow read completion delay");
        end

        fork
            random_traffic(0, random_per_port);
            random_traffic(1, random_per_port);
        join

        for (int i = 0; i < unmapped_checks; i++) begin
            word  = int'(random_bits(8));
            addr  = make_addr(random_nibble(tgt_none), word);
            wdata = random_bits(32);
            transfer_on_a(addr, 1'b1, wdata, 4'hf, cycles);
            transfer_on_b(addr, 1'b0, '0, '0, cycles);
            transfer_on_a(make_addr(4'h0, word), 1'b0, '0, '0, cycles);
            transfer_on_b(make_addr(random_nibble(tgt_slow), word), 1'b0, '0, '0, cycles);
        end

        while (results.size() != 0) begin
            @(posedge clock);
        end
        @(posedge clock);
        $display("** PASS **");
        $finish;
    end

endmodule

/* filelist.f */
hdl/apb_pkg.sv
hdl/apb_if.sv
hdl/apb_arbiter.sv
hdl/apb_delayer.sv
hdl/apb_decoder.sv
hdl/apb_ram.sv
hdl/apb_subsystem.sv
dv/tb_apb_subsystem.sv

/* Makefile */
TOP := tb_apb_subsystem

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -f filelist.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
